//--- source/rv32_pkg.sv
// ========================================
// RV32I base set and user counters only.
// ========================================
`default_nettype none

package rv32_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [3:0] {
		CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
		CLS_LOAD, CLS_STORE, CLS_ALU, CLS_CSR, CLS_ILLEGAL
	} op_class_e;

	typedef struct packed {
		logic eq;
		logic lt;  // Signed
		logic ltu;
	} cmp_flags_t;

	typedef struct packed {
		logic       rs1_use;
		logic       rs2_use;
		logic       rd_use;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		reg_addr_t  rd;
		xlen_t      imm;         // Already sign extended
		op_class_e  op_class;
		alu_op_e    alu_op;
		logic [2:0] funct3;
		logic       alu_src_imm; // b operand from imm
		logic [11:0] csr_addr;
	} dec_t;

	typedef struct packed {
		logic       valid;
		xlen_t      addr;
		xlen_t      wdata;
		logic [3:0] wstrb;
		logic [3:0] rmask;
	} mem_req_t;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_B  = 3'b000; // Memory access sizes
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	localparam logic [2:0] F3_ADD  = 3'b000; // OP and OP-IMM
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

	localparam logic [11:0] CSR_CYCLE    = 12'hC00;
	localparam logic [11:0] CSR_TIME     = 12'hC01;
	localparam logic [11:0] CSR_INSTRET  = 12'hC02;
	localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
	localparam logic [11:0] CSR_TIMEH    = 12'hC81;
	localparam logic [11:0] CSR_INSTRETH = 12'hC82;

	localparam xlen_t PROGADDR_RESET = 32'h0000_0000;
	localparam xlen_t INSN_BYTES     = 32'd4;

endpackage

`default_nettype wire

//--- source/rv32_decode.sv
// ========================================
// 32-bit encodings only; anything outside
// RV32I plus counter reads is illegal.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_decode (
	input  rv32_pkg::xlen_t insn,
	output rv32_pkg::dec_t  dec
);
	import rv32_pkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	logic       is_imm;

	assign opcode = insn[6:0];
	assign funct7 = insn[31:25];
	assign funct3 = insn[14:12];
	assign is_imm = (opcode == OPC_OP_IMM);

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb begin
		logic    alu_legal;
		alu_op_e op;

		alu_legal = 1'b0;
		op = ALU_ADD;
		dec = '0;
		dec.rs1 = insn[19:15];
		dec.rs2 = insn[24:20];
		dec.rd = insn[11:7];
		dec.funct3 = funct3;
		dec.csr_addr = insn[31:20];
		dec.op_class = CLS_ILLEGAL;
		dec.alu_op = ALU_ADD;

		// Mapping from funct3/funct7 onto ALU operations
		unique case (funct3)
			F3_ADD: begin
				alu_legal = is_imm || funct7 == F7_BASE || funct7 == F7_ALT;
				op = (!is_imm && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
			end
			F3_SLL: begin
				alu_legal = (funct7 == F7_BASE); // Shift immediates keep funct7
				op = ALU_SLL;
			end
			F3_SR: begin
				alu_legal = funct7 == F7_BASE || funct7 == F7_ALT;
				op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
			end
			default: begin
				alu_legal = is_imm || funct7 == F7_BASE;
				case (funct3)
					F3_SLT:  op = ALU_SLT;
					F3_SLTU: op = ALU_SLTU;
					F3_XOR:  op = ALU_XOR;
					F3_OR:   op = ALU_OR;
					default: op = ALU_AND;
				endcase
			end
		endcase

		case (opcode)
			OPC_LUI: begin
				dec.op_class = CLS_LUI;
				dec.rd_use = 1'b1;
				dec.imm = imm_u;
			end
			OPC_AUIPC: begin
				dec.op_class = CLS_AUIPC;
				dec.rd_use = 1'b1;
				dec.imm = imm_u;
			end
			OPC_JAL: begin
				dec.op_class = CLS_JAL;
				dec.rd_use = 1'b1;
				dec.imm = imm_j;
			end
			OPC_JALR: begin
				if (funct3 == 3'b000) begin
					dec.op_class = CLS_JALR;
					dec.rs1_use = 1'b1;
					dec.rd_use = 1'b1;
					dec.imm = imm_i;
				end
			end
			OPC_BRANCH: begin
				if (funct3 != 3'b010 && funct3 != 3'b011) begin
					dec.op_class = CLS_BRANCH; // Flags come from rs1 vs rs2
					dec.rs1_use = 1'b1;
					dec.rs2_use = 1'b1;
					dec.imm = imm_b;
				end
			end
			OPC_LOAD: begin
				if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU}) begin
					dec.op_class = CLS_LOAD;
					dec.rs1_use = 1'b1;
					dec.rd_use = 1'b1;
					dec.imm = imm_i;
				end
			end
			OPC_STORE: begin
				if (funct3 inside {F3_B, F3_H, F3_W}) begin
					dec.op_class = CLS_STORE;
					dec.rs1_use = 1'b1;
					dec.rs2_use = 1'b1;
					dec.imm = imm_s;
				end
			end
			OPC_OP, OPC_OP_IMM: begin
				if (alu_legal) begin
					dec.op_class = CLS_ALU;
					dec.alu_op = op;
					dec.rs1_use = 1'b1;
					dec.rs2_use = !is_imm;
					dec.rd_use = 1'b1;
					dec.alu_src_imm = is_imm;
					dec.imm = imm_i;
				end
			end
			OPC_SYSTEM: begin
				// Only csrrs rd, counter, x0 is accepted
				if (funct3 == F3_CSRRS && insn[19:15] == 5'd0 &&
				    insn[31:20] inside {CSR_CYCLE, CSR_TIME, CSR_INSTRET,
				                        CSR_CYCLEH, CSR_TIMEH, CSR_INSTRETH}) begin
					dec.op_class = CLS_CSR;
					dec.rd_use = 1'b1;
				end
			end
			default: dec.op_class = CLS_ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv32_alu.sv
// ========================================
// Shift amount is b[4:0].
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_alu (
	input  rv32_pkg::alu_op_e    op,
	input  rv32_pkg::xlen_t      a,
	input  rv32_pkg::xlen_t      b,
	output rv32_pkg::xlen_t      result,
	output rv32_pkg::cmp_flags_t flags
);
	import rv32_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	// Shared by SLT/SLTU and the branch unit
	assign flags.eq  = (a == b);
	assign flags.lt  = ($signed(a) < $signed(b));
	assign flags.ltu = (a < b);

	always_comb begin
		unique case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $signed(a) >>> shamt; // Sign fills from the top
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, flags.lt};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, flags.ltu};
			ALU_XOR:  result = a ^ b;
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv32_next_pc.sv
// ========================================
// No misaligned-target trap is raised.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_next_pc (
	input  rv32_pkg::xlen_t      pc,
	input  rv32_pkg::dec_t       dec,
	input  rv32_pkg::xlen_t      rs1_value,
	input  rv32_pkg::cmp_flags_t flags,
	output rv32_pkg::xlen_t      pc_next,
	output rv32_pkg::xlen_t      pc_plus4
);
	import rv32_pkg::*;

	xlen_t pc_target;
	xlen_t jalr_target;
	logic  taken;

	assign pc_plus4    = pc + INSN_BYTES;
	assign pc_target   = pc + dec.imm;                                // JAL and branches
	assign jalr_target = (rs1_value + dec.imm) & ~xlen_t'(1);

	always_comb begin
		case (dec.funct3)
			F3_BEQ:  taken = flags.eq;
			F3_BNE:  taken = !flags.eq;
			F3_BLT:  taken = flags.lt;
			F3_BGE:  taken = !flags.lt;
			F3_BLTU: taken = flags.ltu;
			F3_BGEU: taken = !flags.ltu;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.op_class)
			CLS_JAL:    pc_next = pc_target;
			CLS_JALR:   pc_next = jalr_target;
			CLS_BRANCH: pc_next = taken ? pc_target : pc_plus4;
			default:    pc_next = pc_plus4;
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv32_lsu.sv
// ========================================
// Lanes are not shifted by addr[1:0]; loads use
// the low lanes, stores go out unshifted.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_lsu (
	input  rv32_pkg::dec_t     dec,
	input  rv32_pkg::xlen_t    rs1_value,
	input  rv32_pkg::xlen_t    rs2_value,
	input  rv32_pkg::xlen_t    mem_rdata,
	output rv32_pkg::mem_req_t mem_req,
	output rv32_pkg::xlen_t    load_data
);
	import rv32_pkg::*;

	logic is_load;
	logic is_store;
	logic [3:0] size_mask;

	assign is_load  = (dec.op_class == CLS_LOAD);
	assign is_store = (dec.op_class == CLS_STORE);

	always_comb begin
		case (dec.funct3)
			F3_B, F3_BU: size_mask = 4'b0001;
			F3_H, F3_HU: size_mask = 4'b0011;
			default:     size_mask = 4'b1111;
		endcase
	end

	assign mem_req.valid = is_load || is_store; // Gated again in the core
	assign mem_req.addr  = rs1_value + dec.imm;
	assign mem_req.wdata = is_store ? rs2_value : '0;
	assign mem_req.wstrb = is_store ? size_mask : 4'b0000;
	assign mem_req.rmask = is_load ? size_mask : 4'b0000;

	always_comb begin
		case (dec.funct3)
			F3_B:    load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			F3_BU:   load_data = {24'b0, mem_rdata[7:0]};
			F3_H:    load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			F3_HU:   load_data = {16'b0, mem_rdata[15:0]};
			default: load_data = mem_rdata;
		endcase
	end

endmodule

`default_nettype wire

//--- source/rv32_regfile.sv
// ========================================
// x0 is hardwired to zero.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile (
	input  logic                clk,
	input  logic                arst_n,
	input  rv32_pkg::reg_addr_t rs1_addr,
	input  rv32_pkg::reg_addr_t rs2_addr,
	input  rv32_pkg::reg_addr_t rd_addr,
	input  logic                rd_we,
	input  rv32_pkg::xlen_t     rd_wdata,
	output rv32_pkg::xlen_t     rs1_rdata,
	output rv32_pkg::xlen_t     rs2_rdata
);
	import rv32_pkg::*;

	xlen_t regs [1:31]; // No storage for x0

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_addr != '0) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/rv32_core.sv
// ========================================
// Single cycle, one instruction in flight. Memory
// lanes unshifted; trap halts until reset.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
	input  logic               clk,
	input  logic               arst_n,
	output rv32_pkg::xlen_t    insn_addr,
	input  rv32_pkg::xlen_t    insn,
	input  logic               insn_valid,
	output logic               insn_complete,
	output rv32_pkg::mem_req_t mem_req,
	input  logic               mem_ready,
	input  rv32_pkg::xlen_t    mem_rdata,
	output logic               trap
);
	import rv32_pkg::*;

	xlen_t       pc, pc_next, pc_plus4;
	logic        halted;
	logic [63:0] cycle_cnt, instret_cnt;
	dec_t        dec;
	cmp_flags_t  flags;
	mem_req_t    lsu_req;
	reg_addr_t   rs1_addr, rs2_addr;
	xlen_t       rs1_value, rs2_value, alu_b, alu_result;
	xlen_t       load_data, csr_value, rd_wdata;
	logic        illegal, mem_ok, rd_we;

	rv32_decode rv32_decode_inst (.insn(insn), .dec(dec));

	assign rs1_addr = dec.rs1_use ? dec.rs1 : '0; // Unused ports read x0
	assign rs2_addr = dec.rs2_use ? dec.rs2 : '0;

	rv32_regfile rv32_regfile_inst (
		.clk(clk), .arst_n(arst_n),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(dec.rd),
		.rd_we(rd_we), .rd_wdata(rd_wdata),
		.rs1_rdata(rs1_value), .rs2_rdata(rs2_value)
	);

	assign alu_b = dec.alu_src_imm ? dec.imm : rs2_value;

	rv32_alu rv32_alu_inst (
		.op(dec.alu_op), .a(rs1_value), .b(alu_b), .result(alu_result), .flags(flags)
	);

	rv32_next_pc rv32_next_pc_inst (
		.pc(pc), .dec(dec), .rs1_value(rs1_value), .flags(flags),
		.pc_next(pc_next), .pc_plus4(pc_plus4)
	);

	rv32_lsu rv32_lsu_inst (
		.dec(dec), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.mem_rdata(mem_rdata), .mem_req(lsu_req), .load_data(load_data)
	);

	always_comb begin
		mem_req = lsu_req;
		mem_req.valid = lsu_req.valid && insn_valid && !halted;
	end

	assign illegal       = (dec.op_class == CLS_ILLEGAL);
	assign mem_ok        = !mem_req.valid || mem_ready;
	assign insn_complete = insn_valid && !halted && !illegal && mem_ok;
	assign trap          = halted || (insn_valid && illegal);
	assign insn_addr     = pc;
	assign rd_we         = insn_complete && dec.rd_use;

	always_comb begin
		case (dec.csr_addr)
			CSR_CYCLE, CSR_TIME:   csr_value = cycle_cnt[31:0]; // Time tracks cycle
			CSR_CYCLEH, CSR_TIMEH: csr_value = cycle_cnt[63:32];
			CSR_INSTRET:           csr_value = instret_cnt[31:0];
			CSR_INSTRETH:          csr_value = instret_cnt[63:32];
			default:               csr_value = '0;
		endcase
	end

	always_comb begin
		case (dec.op_class)
			CLS_LUI:            rd_wdata = dec.imm;
			CLS_AUIPC:          rd_wdata = pc + dec.imm;
			CLS_JAL, CLS_JALR:  rd_wdata = pc_plus4; // Link address
			CLS_LOAD:           rd_wdata = load_data;
			CLS_ALU:            rd_wdata = alu_result;
			CLS_CSR:            rd_wdata = csr_value;
			default:            rd_wdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= PROGADDR_RESET;
			halted      <= 1'b0;
			cycle_cnt   <= '0;
			instret_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 64'd1;
			if (trap) halted <= 1'b1; // Sticky until reset
			if (insn_complete) begin
				pc          <= pc_next;
				instret_cnt <= instret_cnt + 64'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/rv32_core_tb_program.svh
// ========================================
// Program rows in execution order; each row's PC
// is the previous row's expected next address.
// ========================================
`ifndef RV32_CORE_TB_PROGRAM_SVH
`define RV32_CORE_TB_PROGRAM_SVH

task automatic add_row(input xlen_t word, input xlen_t next, input logic mem,
		input xlen_t addr, input xlen_t wdata, input logic [3:0] wstrb,
		input logic [3:0] rmask, input xlen_t rdata, input logic trap_exp);
	row_t r;

	r = '{pc: cur_pc, insn: word, next: next, mem: mem, addr: addr, wdata: wdata,
		wstrb: wstrb, rmask: rmask, rdata: rdata, trap: trap_exp};
	rows[n_rows] = r;
	n_rows++;
	cur_pc = next;
endtask

task automatic step(input xlen_t word);
	add_row(word, cur_pc + 4, 1'b0, '0, '0, 4'b0000, 4'b0000, '0, 1'b0);
endtask

task automatic jmp(input xlen_t word, input xlen_t target);
	add_row(word, target, 1'b0, '0, '0, 4'b0000, 4'b0000, '0, 1'b0);
endtask

// SW rs, off(x10) with a fresh offset each time
task automatic sw(input logic [4:0] rs, input xlen_t val);
	add_row(enc_s(12'(st_off), rs, 10, 3'b010), cur_pc + 4, 1'b1, 32'h100 + st_off, val,
		4'b1111, 4'b0000, '0, 1'b0);
	st_off += 4;
endtask

task automatic op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
	step(enc_r(f7, rs2, rs1, f3, 4, 7'h33)); // Result in x4
endtask

task automatic opi(input logic [11:0] imm, input logic [2:0] f3, input logic [4:0] rs1);
	step(enc_i(imm, rs1, f3, 4, 7'h13));
endtask

// Load into x5 from 0x140 + off(x10)
task automatic ld(input logic [2:0] f3, input logic [3:0] rmask, input xlen_t rdata);
	add_row(enc_i(12'h040, 10, f3, 5, 7'h03), cur_pc + 4, 1'b1, 32'h140, '0,
		4'b0000, rmask, rdata, 1'b0);
endtask

task automatic br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic taken);
	jmp(enc_b(13'd8, rs2, rs1, f3), taken ? cur_pc + 8 : cur_pc + 4);
endtask

task automatic load_program();
	xlen_t link;
	xlen_t jal_link;
	xlen_t value;

	n_rows = 0;
	cur_pc = 32'h0;
	st_off = 0;
	step(enc_u(20'h80000, 1, 7'h37));           // x1 = 0x80000000
	step(enc_i(12'h100, 0, 3'b000, 10, 7'h13)); // x10 = data base
	step(enc_i(12'hFF8, 0, 3'b000, 2, 7'h13));  // x2 = -8
	step(enc_i(12'h003, 0, 3'b000, 3, 7'h13));  // x3 = 3
	op(7'h00, 3'b000, 2, 3);
	sw(4, 32'hFFFF_FFFB);
	op(7'h20, 3'b000, 3, 2);
	sw(4, 32'h0000_000B);
	op(7'h00, 3'b001, 3, 3);
	sw(4, 32'h0000_0018);
	op(7'h00, 3'b101, 2, 3);
	sw(4, 32'h1FFF_FFFF);
	op(7'h20, 3'b101, 2, 3);
	sw(4, 32'hFFFF_FFFF);                        // SRA keeps the sign
	op(7'h00, 3'b010, 2, 3);
	sw(4, 32'h1);
	op(7'h00, 3'b011, 2, 3);
	sw(4, 32'h0);                                // Same operands, unsigned
	op(7'h00, 3'b100, 2, 3);
	sw(4, 32'hFFFF_FFFB);
	op(7'h00, 3'b110, 1, 3);
	sw(4, 32'h8000_0003);
	op(7'h00, 3'b111, 2, 1);
	sw(4, 32'h8000_0000);
	opi(12'hFF9, 3'b010, 2);
	sw(4, 32'h1);
	opi(12'hFFF, 3'b011, 3);
	sw(4, 32'h1);
	opi(12'h0F0, 3'b110, 3);
	sw(4, 32'h0000_00F3);
	opi(12'h0FF, 3'b111, 2);
	sw(4, 32'h0000_00F8);
	opi(12'h01F, 3'b001, 3);
	sw(4, 32'h8000_0000);
	opi(12'h01F, 3'b101, 1);
	sw(4, 32'h1);
	opi(12'h404, 3'b101, 1);
	sw(4, 32'hF800_0000);
	opi(12'h7FF, 3'b100, 3);
	sw(4, 32'h0000_07FC);
	value = cur_pc + 32'h1000;
	step(enc_u(20'h00001, 4, 7'h17));
	sw(4, value);
	ld(3'b000, 4'b0001, 32'h1234_5680);
	sw(5, 32'hFFFF_FF80);
	ld(3'b100, 4'b0001, 32'h1234_5680);
	sw(5, 32'h0000_0080);
	ld(3'b001, 4'b0011, 32'hABCD_8001);
	sw(5, 32'hFFFF_8001);
	ld(3'b101, 4'b0011, 32'hABCD_8001);
	sw(5, 32'h0000_8001);
	ld(3'b010, 4'b1111, 32'hDEAD_BEEF);
	sw(5, 32'hDEAD_BEEF);
	add_row(enc_s(12'h003, 3, 10, 3'b000), cur_pc + 4, 1'b1, 32'h103, 32'h3,
		4'b0001, 4'b0000, '0, 1'b0);
	add_row(enc_s(12'h006, 2, 10, 3'b001), cur_pc + 4, 1'b1, 32'h106, 32'hFFFF_FFF8,
		4'b0011, 4'b0000, '0, 1'b0);
	br(3'b000, 3, 3, 1'b1);
	br(3'b000, 3, 2, 1'b0);
	br(3'b001, 3, 2, 1'b1);
	br(3'b001, 3, 3, 1'b0);
	br(3'b100, 2, 3, 1'b1);
	br(3'b100, 3, 2, 1'b0);
	br(3'b101, 3, 2, 1'b1);
	br(3'b101, 2, 3, 1'b0);
	br(3'b110, 3, 2, 1'b1);
	br(3'b110, 2, 3, 1'b0);
	br(3'b111, 2, 3, 1'b1);
	br(3'b111, 3, 2, 1'b0);
	jal_link = cur_pc + 4;
	jmp(enc_j(21'd12, 6), cur_pc + 12);
	sw(6, jal_link);
	link = cur_pc + 4;
	jmp(enc_i(12'h021, 6, 3'b000, 7, 7'h67), (jal_link + 32'h21) & ~32'h1);
	sw(7, link);
	value = xlen_t'(n_rows);                     // Rows so far all complete
	step(enc_i(12'hC02, 0, 3'b010, 8, 7'h73));
	sw(8, value);
	add_row(32'h0000_0000, cur_pc, 1'b0, '0, '0, 4'b0000, 4'b0000, '0, 1'b1);
endtask

`endif

//--- bench/rv32_core_tb.sv
// ========================================
// Walks the program table row by row; rows
// must be given in execution order.
// ========================================
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb;
	import rv32_pkg::*;

	typedef struct packed {
		xlen_t      pc;
		xlen_t      insn;
		xlen_t      next;  // Expected fetch address afterwards
		logic       mem;
		xlen_t      addr;
		xlen_t      wdata;
		logic [3:0] wstrb;
		logic [3:0] rmask;
		xlen_t      rdata; // Returned to loads
		logic       trap;
	} row_t;

	localparam int MAX_ROWS = 128;

	logic     clk;
	logic     arst_n;
	xlen_t    insn_addr;
	xlen_t    insn;
	logic     insn_valid;
	logic     insn_complete;
	mem_req_t mem_req;
	logic     mem_ready;
	xlen_t    mem_rdata;
	logic     trap;

	row_t  rows [MAX_ROWS];
	int    n_rows;
	xlen_t cur_pc;
	int    st_off;
	int    errors = 0;
	int    rows_bad = 0;
	logic  row_bad;
	int    cycles = 0;
	int    limit = 1000;

	rv32_core rv32_core_inst (
		.clk(clk), .arst_n(arst_n), .insn_addr(insn_addr), .insn(insn),
		.insn_valid(insn_valid), .insn_complete(insn_complete), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .trap(trap)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (arst_n) begin
			cycles++;
			if (cycles > limit) begin
				$display("Timeout after %0d cycles without finishing the program", cycles);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	function automatic xlen_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic xlen_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic xlen_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic xlen_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic xlen_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic xlen_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
	endfunction

	`include "rv32_core_tb_program.svh"

	task automatic check(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
			row_bad = 1'b1;
		end
	endtask

	function automatic int find_row(xlen_t addr);
		for (int k = 0; k < n_rows; k++) begin
			if (rows[k].pc == addr) return k;
		end
		return -1;
	endfunction

	task automatic check_request(input row_t r);
		check("mem_req.valid", xlen_t'(mem_req.valid), xlen_t'(r.mem));
		if (r.mem) begin
			check("mem_req.addr", mem_req.addr, r.addr);
			check("mem_req.wdata", mem_req.wdata, r.wdata);
			check("mem_req.wstrb", xlen_t'(mem_req.wstrb), xlen_t'(r.wstrb));
			check("mem_req.rmask", xlen_t'(mem_req.rmask), xlen_t'(r.rmask));
		end
	endtask

	task automatic run_row(input int i);
		row_t r;
		int   idx;
		int   wait_cycles;

		r = rows[i];
		row_bad = 1'b0;
		check("insn_addr", insn_addr, r.pc);
		idx = find_row(insn_addr);
		if (idx < 0) begin
			$display("Fetch address %h is not in the program", insn_addr);
			errors++;
			row_bad = 1'b1;
			idx = i;
		end
		insn = rows[idx].insn;
		insn_valid = 1'b1;
		mem_rdata = rows[idx].rdata;
		wait_cycles = r.mem ? int'($urandom % 4) : 0;
		mem_ready = (wait_cycles == 0);
		forever begin
			#1;
			check_request(r); // Must hold while mem_ready is low
			if (insn_complete || trap) break;
			@(negedge clk);
			wait_cycles--;
			mem_ready = (wait_cycles <= 0);
		end
		check("trap", xlen_t'(trap), xlen_t'(r.trap));
		check("insn_complete", xlen_t'(insn_complete), xlen_t'(!r.trap));
		@(negedge clk);
		check("next insn_addr", insn_addr, r.next);
		if (r.trap) begin
			insn = enc_s(12'h000, 5'd3, 5'd10, F3_W); // Legal SW, halt must block it
			mem_ready = 1'b1;
			repeat (5) begin
				#1;
				check("halted insn_addr", insn_addr, r.pc);
				check("halted mem_req.valid", xlen_t'(mem_req.valid), '0);
				check("halted trap", xlen_t'(trap), 32'h1);
				check("halted insn_complete", xlen_t'(insn_complete), '0);
				@(negedge clk);
			end
		end
		if (row_bad) rows_bad++;
		$display("Row %0d at %h: %s", i, r.pc, row_bad ? "mismatch" : "ok");
	endtask

	initial begin
		void'($urandom(87025));
		clk = 1'b0;
		arst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		load_program();
		limit = n_rows * 6 + 20;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			run_row(i);
		end
		$display("Rows %0d, passed %0d, failed %0d, mismatches %0d",
			n_rows, n_rows - rows_bad, rows_bad, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
source/rv32_pkg.sv
source/rv32_decode.sv
source/rv32_alu.sv
source/rv32_next_pc.sv
source/rv32_lsu.sv
source/rv32_regfile.sv
source/rv32_core.sv
bench/rv32_core_tb.sv

//--- Bender.yml
package:
  name: rv32_core

sources:
  - source/rv32_pkg.sv
  - source/rv32_decode.sv
  - source/rv32_alu.sv
  - source/rv32_next_pc.sv
  - source/rv32_lsu.sv
  - source/rv32_regfile.sv
  - source/rv32_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rv32_core_tb.sv
